//--- design/chess_pkg.sv
/*
  Board level definitions for the chess subsystem: piece codes, square
  coordinates, commands and the board access request and response structs.
  Imported by every module that touches the board.
*/
package chess_pkg;

  localparam int NUM_RANKS   = 8;
  localparam int FIRST_WHITE = 7;  // Codes from here up are white pieces

  typedef logic [3:0] piece_t;
  typedef logic [2:0] coord_t;  // File or rank index

  // Black codes; white code is black code plus six
  localparam piece_t PIECE_EMPTY  = 4'd0;
  localparam piece_t PIECE_PAWN   = 4'd1;
  localparam piece_t PIECE_KNIGHT = 4'd2;
  localparam piece_t PIECE_BISHOP = 4'd3;
  localparam piece_t PIECE_ROOK   = 4'd4;
  localparam piece_t PIECE_QUEEN  = 4'd5;
  localparam piece_t PIECE_KING   = 4'd6;

  typedef struct packed {
    coord_t file;
    coord_t rank;
  } square_t;

  typedef logic [0:0] requester_t;
  localparam requester_t REQ_CTRL   = 1'b0;
  localparam requester_t REQ_RENDER = 1'b1;

  typedef struct packed {
    logic       valid;
    logic       write;
    square_t    square;
    piece_t     wdata;
    requester_t tag;
  } board_req_t;

  typedef struct packed {
    logic       valid;
    requester_t tag;
    piece_t     rdata;
  } board_rsp_t;

  typedef enum logic [1:0] {CMD_NONE, CMD_INIT, CMD_MOVE} cmd_op_t;

  typedef struct packed {
    cmd_op_t op;
    square_t origin;
    square_t dest;
  } board_cmd_t;

  function automatic piece_t to_white(piece_t black);
    return black + piece_t'(FIRST_WHITE - 1);
  endfunction

  function automatic logic is_white(piece_t piece);
    return piece >= piece_t'(FIRST_WHITE);
  endfunction

endpackage

//--- design/video_pkg.sv
/*
  Display side definitions: pixel coordinates, the pixel write struct,
  tile geometry and the pixel credit count toward the frame buffer.
*/
package video_pkg;

  localparam int TILE_SIZE     = 8;  // Pixels per square edge
  localparam int PIXEL_CREDITS = 4;  // Frame buffer slots at reset

  typedef logic [8:0] pix_x_t;
  typedef logic [7:0] pix_y_t;

  // Holds 0 to PIXEL_CREDITS
  typedef logic [2:0] credit_cnt_t;

  typedef struct packed {
    pix_x_t x;
    pix_y_t y;
    logic   colour;  // Monochrome, 1 is lit
  } pixel_t;

endpackage

//--- design/board_ctrl.sv
/*
  Board controller FSM. Takes init and move commands, writes the starting
  layout or reads the origin and moves its piece, then pulses cmd_done.
*/
`timescale 1ns/100ps

module board_ctrl (
  input  logic                  clk,
  input  logic                  arst_n,
  input  chess_pkg::board_cmd_t cmd,
  input  logic                  cmd_valid,
  output logic                  cmd_ready,
  output logic                  cmd_done,
  output logic                  cmd_err,
  output chess_pkg::board_req_t req,
  input  logic                  grant,
  input  chess_pkg::board_rsp_t rsp
);
  import chess_pkg::*;

  typedef enum logic [2:0] {
    IDLE, INIT_WR, MV_RD, MV_WAIT, MV_WR_DST, MV_WR_ORG, DONE
  } state_t;

  state_t     state;
  board_cmd_t cmd_q;
  square_t    init_sq;
  piece_t     moved_q;
  logic       err_q;
  logic       rsp_hit;
  logic       take_cmd;

  // Starting position piece for one square
  function automatic piece_t start_piece(square_t sq);
    piece_t kind;
    case (sq.file)
      3'd0, 3'd7: kind = PIECE_ROOK;
      3'd1, 3'd6: kind = PIECE_KNIGHT;
      3'd2, 3'd5: kind = PIECE_BISHOP;
      3'd3:       kind = PIECE_QUEEN;
      default:    kind = PIECE_KING;
    endcase
    case (sq.rank)
      3'd0:    return to_white(kind);
      3'd1:    return to_white(PIECE_PAWN);
      3'd6:    return PIECE_PAWN;
      3'd7:    return kind;
      default: return PIECE_EMPTY;
    endcase
  endfunction

  assign take_cmd  = cmd_valid && cmd_ready;
  assign rsp_hit   = rsp.valid && (rsp.tag == REQ_CTRL);
  assign cmd_ready = (state == IDLE);
  assign cmd_done  = (state == DONE);
  assign cmd_err   = (state == DONE) && err_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= IDLE;
      init_sq <= '0;
      err_q   <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          err_q   <= 1'b0;
          init_sq <= '0;
          if (take_cmd && cmd.op == CMD_INIT) state <= INIT_WR;
          else if (take_cmd && cmd.op == CMD_MOVE) state <= MV_RD;
        end
        INIT_WR: if (grant) begin
          init_sq <= init_sq + 6'd1;
          if (init_sq == '1) state <= DONE;  // All 64 squares written
        end
        MV_RD:   if (grant) state <= MV_WAIT;
        MV_WAIT: if (rsp_hit) begin
          // Refuse empty origin and null move
          if (rsp.rdata == PIECE_EMPTY || cmd_q.origin == cmd_q.dest) begin
            err_q <= 1'b1;
            state <= DONE;
          end else begin
            state <= MV_WR_DST;
          end
        end
        MV_WR_DST: if (grant) state <= MV_WR_ORG;
        MV_WR_ORG: if (grant) state <= DONE;
        default:   state <= IDLE;  // DONE lasts one cycle
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take_cmd) cmd_q <= cmd;
    if (state == MV_WAIT && rsp_hit) moved_q <= rsp.rdata;
  end

  always_comb begin
    req     = '0;
    req.tag = REQ_CTRL;
    case (state)
      INIT_WR: begin
        req.valid  = 1'b1;
        req.write  = 1'b1;
        req.square = init_sq;
        req.wdata  = start_piece(init_sq);
      end
      MV_RD: begin
        req.valid  = 1'b1;
        req.square = cmd_q.origin;
      end
      MV_WR_DST: begin
        req.valid  = 1'b1;
        req.write  = 1'b1;
        req.square = cmd_q.dest;  // Capture just overwrites
        req.wdata  = moved_q;
      end
      MV_WR_ORG: begin
        req.valid  = 1'b1;
        req.write  = 1'b1;
        req.square = cmd_q.origin;
        req.wdata  = PIECE_EMPTY;
      end
      default: ;
    endcase
  end

endmodule

//--- design/board_port_arbiter.sv
/*
  Fixed priority arbiter for the board. The controller wins over the
  renderer; the granted access is steered to the one rank it addresses.
*/
`timescale 1ns/100ps

module board_port_arbiter (
  input  logic                                clk,
  input  logic                                arst_n,
  input  chess_pkg::board_req_t               ctrl_req,
  input  chess_pkg::board_req_t               render_req,
  output logic                                ctrl_grant,
  output logic                                render_grant,
  output logic [chess_pkg::NUM_RANKS-1:0]     rank_we,
  output logic [chess_pkg::NUM_RANKS-1:0]     rank_re,
  output chess_pkg::coord_t                   rank_file,
  output chess_pkg::piece_t                   rank_wdata,
  output logic                                rd_valid,
  output chess_pkg::requester_t               rd_tag,
  output chess_pkg::coord_t                   rd_rank
);
  import chess_pkg::*;

  board_req_t sel;
  logic       granted;

  assign ctrl_grant   = ctrl_req.valid;
  assign render_grant = render_req.valid && !ctrl_req.valid;

  assign sel     = ctrl_req.valid ? ctrl_req : render_req;
  assign granted = sel.valid;

  // Rank decode
  always_comb begin
    rank_we = '0;
    rank_re = '0;
    rank_we[sel.square.rank] = granted && sel.write;
    rank_re[sel.square.rank] = granted && !sel.write;
  end

  assign rank_file  = sel.square.file;
  assign rank_wdata = sel.wdata;

  // Read info delayed to meet the registered rank data
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_valid <= 1'b0;
      rd_tag   <= REQ_CTRL;
      rd_rank  <= '0;
    end else begin
      rd_valid <= granted && !sel.write;
      rd_tag   <= sel.tag;
      rd_rank  <= sel.square.rank;
    end
  end

endmodule

//--- design/board_rank.sv
/*
  One rank of the board: eight piece registers addressed by file.
  Writes land at the end of the cycle, reads come back one cycle later.
*/
`timescale 1ns/100ps

module board_rank (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              we,
  input  logic              re,
  input  chess_pkg::coord_t file,
  input  chess_pkg::piece_t wdata,
  output chess_pkg::piece_t rdata
);
  import chess_pkg::*;

  piece_t squares [2**$bits(coord_t)];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 2**$bits(coord_t); i++) begin
        squares[i] <= PIECE_EMPTY;
      end
      rdata <= PIECE_EMPTY;
    end else begin
      if (we) squares[file] <= wdata;
      if (re) rdata <= squares[file];  // Held until the next read
    end
  end

endmodule

//--- design/rank_read_merge.sv
/*
  Read return path. Picks the data of the rank that was read and registers
  it with the requester tag; both requesters watch the same response.
*/
`timescale 1ns/100ps

module rank_read_merge (
  input  logic                  clk,
  input  logic                  arst_n,
  input  chess_pkg::piece_t     rank_rdata [chess_pkg::NUM_RANKS],
  input  logic                  rd_valid,
  input  chess_pkg::requester_t rd_tag,
  input  chess_pkg::coord_t     rd_rank,
  output chess_pkg::board_rsp_t rsp
);
  import chess_pkg::*;

  logic       valid_q;
  requester_t tag_q;
  piece_t     data_q;
  piece_t     sel_data;

  assign sel_data = rank_rdata[rd_rank];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
      tag_q   <= REQ_CTRL;
    end else begin
      valid_q <= rd_valid;
      tag_q   <= rd_tag;
    end
  end

  // Data only moves on a real read
  always_ff @(posedge clk) begin
    if (rd_valid) data_q <= sel_data;
  end

  assign rsp = '{valid: valid_q, tag: tag_q, rdata: data_q};

endmodule

//--- design/board_render.sv
/*
  Board renderer. On render_start it reads each square rank by rank and
  sends its 8x8 tile to the frame buffer, one pixel per available credit.
*/
`timescale 1ns/100ps

module board_render (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  render_start,
  output logic                  render_done,
  output chess_pkg::board_req_t req,
  input  logic                  grant,
  input  chess_pkg::board_rsp_t rsp,
  output video_pkg::pixel_t     pix,
  output logic                  pix_valid,
  input  logic                  pix_credit
);
  import chess_pkg::*;
  import video_pkg::*;

  typedef enum logic [2:0] {IDLE, TILE_RD, TILE_WAIT, TILE_PIX, DONE} state_t;

  state_t      state;
  coord_t      file_q;
  coord_t      rank_q;
  coord_t      col_q;
  coord_t      row_q;
  piece_t      piece_q;
  credit_cnt_t credit_q;
  logic        col_last;
  logic        row_last;
  logic        shade;
  logic        border;
  logic        colour;

  assign col_last = (col_q == coord_t'(TILE_SIZE - 1));
  assign row_last = (row_q == coord_t'(TILE_SIZE - 1));

  assign render_done = (state == DONE);
  assign pix_valid   = (state == TILE_PIX) && (credit_q != '0);

  always_comb begin
    req        = '0;
    req.tag    = REQ_RENDER;
    req.valid  = (state == TILE_RD);
    req.square = '{file: file_q, rank: rank_q};
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= IDLE;
      file_q <= '0;
      rank_q <= '0;
      col_q  <= '0;
      row_q  <= '0;
    end else begin
      case (state)
        IDLE: if (render_start) begin
          file_q <= '0;
          rank_q <= '0;
          state  <= TILE_RD;
        end
        TILE_RD:   if (grant) state <= TILE_WAIT;
        TILE_WAIT: if (rsp.valid && rsp.tag == REQ_RENDER) state <= TILE_PIX;
        TILE_PIX: if (pix_valid) begin
          col_q <= col_q + 3'd1;
          if (col_last) row_q <= row_q + 3'd1;
          if (col_last && row_last) begin
            // Tile finished, step file then rank
            file_q <= file_q + 3'd1;
            if (file_q == '1) rank_q <= rank_q + 3'd1;
            if (file_q == '1 && rank_q == '1) state <= DONE;
            else state <= TILE_RD;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == TILE_WAIT && rsp.valid && rsp.tag == REQ_RENDER) piece_q <= rsp.rdata;
  end

  // One credit back per consumed pixel, one spent per pixel sent
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      credit_q <= credit_cnt_t'(PIXEL_CREDITS);
    end else begin
      case ({pix_credit, pix_valid})
        2'b10:   credit_q <= credit_q + 3'd1;
        2'b01:   credit_q <= credit_q - 3'd1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  always_comb begin
    shade  = file_q[0] ^ rank_q[0];  // Odd square sum is light
    border = (col_q == '0) || col_last || (row_q == '0) || row_last;
    if (border || piece_q == PIECE_EMPTY) colour = shade;
    else colour = is_white(piece_q);
  end

  assign pix = '{
    x:      pix_x_t'(file_q) * pix_x_t'(TILE_SIZE) + pix_x_t'(col_q),
    y:      pix_y_t'(rank_q) * pix_y_t'(TILE_SIZE) + pix_y_t'(row_q),
    colour: colour
  };

endmodule

//--- design/chess_top.sv
/*
  Chess board and display subsystem. Commands drive the board controller,
  render_start walks the board into the frame buffer under credit control.
*/
`timescale 1ns/100ps

module chess_top (
  input  logic                  clk,
  input  logic                  arst_n,
  input  chess_pkg::board_cmd_t cmd,
  input  logic                  cmd_valid,
  output logic                  cmd_ready,
  output logic                  cmd_done,
  output logic                  cmd_err,
  input  logic                  render_start,
  output logic                  render_done,
  output video_pkg::pixel_t     pix,
  output logic                  pix_valid,
  input  logic                  pix_credit
);
  import chess_pkg::*;

  board_req_t             ctrl_req;
  board_req_t             render_req;
  logic                   ctrl_grant;
  logic                   render_grant;
  logic [NUM_RANKS-1:0]   rank_we;
  logic [NUM_RANKS-1:0]   rank_re;
  coord_t                 rank_file;
  piece_t                 rank_wdata;
  piece_t                 rank_rdata [NUM_RANKS];
  logic                   rd_valid;
  requester_t             rd_tag;
  coord_t                 rd_rank;
  board_rsp_t             rsp;

  board_ctrl i_board_ctrl (
    .clk       (clk),
    .arst_n    (arst_n),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_done  (cmd_done),
    .cmd_err   (cmd_err),
    .req       (ctrl_req),
    .grant     (ctrl_grant),
    .rsp       (rsp)
  );

  board_port_arbiter i_board_port_arbiter (
    .clk          (clk),
    .arst_n       (arst_n),
    .ctrl_req     (ctrl_req),
    .render_req   (render_req),
    .ctrl_grant   (ctrl_grant),
    .render_grant (render_grant),
    .rank_we      (rank_we),
    .rank_re      (rank_re),
    .rank_file    (rank_file),
    .rank_wdata   (rank_wdata),
    .rd_valid     (rd_valid),
    .rd_tag       (rd_tag),
    .rd_rank      (rd_rank)
  );

  for (genvar r = 0; r < NUM_RANKS; r++) begin : g_rank
    board_rank i_board_rank (
      .clk    (clk),
      .arst_n (arst_n),
      .we     (rank_we[r]),
      .re     (rank_re[r]),
      .file   (rank_file),
      .wdata  (rank_wdata),
      .rdata  (rank_rdata[r])
    );
  end

  rank_read_merge i_rank_read_merge (
    .clk        (clk),
    .arst_n     (arst_n),
    .rank_rdata (rank_rdata),
    .rd_valid   (rd_valid),
    .rd_tag     (rd_tag),
    .rd_rank    (rd_rank),
    .rsp        (rsp)
  );

  board_render i_board_render (
    .clk          (clk),
    .arst_n       (arst_n),
    .render_start (render_start),
    .render_done  (render_done),
    .req          (render_req),
    .grant        (render_grant),
    .rsp          (rsp),
    .pix          (pix),
    .pix_valid    (pix_valid),
    .pix_credit   (pix_credit)
  );

endmodule

//--- test/tb_clock_gen.sv
/*
  Clock and reset source for the chess testbench. Makes a 4 ns clock and
  holds the active low reset for the first 8 cycles.
*/
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter real PERIOD_NS    = 4.0,
  parameter int  RESET_CYCLES = 8
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;  // Released away from the active edge
  end

endmodule

//--- test/tb_chess_top.sv
/*
  Directed testbench for the chess board and display subsystem. Each test
  drives commands and renders, and a frame buffer model returns pixel
  credits and checks every pixel against a board model.
*/
`timescale 1ns/100ps

module tb_chess_top;
  import chess_pkg::*;
  import video_pkg::*;

  localparam int BOARD_PIX = NUM_RANKS * TILE_SIZE;  // Pixels per board edge
  // Seven renders of 64 tiles at up to 64 + 8 cycles each, plus reset and commands
  localparam int TIMEOUT_CYCLES = 7 * 64 * (64 + 8) + 2000;

  logic        clk;
  logic        arst_n;
  board_cmd_t  cmd;
  logic        cmd_valid;
  logic        cmd_ready;
  logic        cmd_done;
  logic        cmd_err;
  logic        render_start;
  logic        render_done;
  pixel_t      pix;
  logic        pix_valid;
  logic        pix_credit;

  piece_t      board_model [8][8];  // Indexed [rank][file]
  bit          seen [BOARD_PIX][BOARD_PIX];
  int          pix_count;
  logic [31:0] lfsr_state;
  int          errors;
  int          tests_run;
  int          tests_failed;

  tb_clock_gen i_tb_clock_gen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  chess_top i_chess_top (
    .clk          (clk),
    .arst_n       (arst_n),
    .cmd          (cmd),
    .cmd_valid    (cmd_valid),
    .cmd_ready    (cmd_ready),
    .cmd_done     (cmd_done),
    .cmd_err      (cmd_err),
    .render_start (render_start),
    .render_done  (render_done),
    .pix          (pix),
    .pix_valid    (pix_valid),
    .pix_credit   (pix_credit)
  );

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic int lfsr_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);  // One step per bit
      v = (v << 1) | lfsr_state[0];
    end
    return v;
  endfunction

  function automatic square_t sq_at(input int file_i, input int rank_i);
    square_t s;
    s.file = coord_t'(file_i);
    s.rank = coord_t'(rank_i);
    return s;
  endfunction

  // Standard opening layout, black codes 1 to 6 and white six higher
  function automatic piece_t start_piece_of(input int file_i, input int rank_i);
    int back [8] = '{4, 2, 3, 5, 6, 3, 2, 4};
    case (rank_i)
      0:       return piece_t'(back[file_i] + 6);
      1:       return piece_t'(7);
      6:       return piece_t'(1);
      7:       return piece_t'(back[file_i]);
      default: return piece_t'(0);
    endcase
  endfunction

  function automatic logic expected_colour(input int x, input int y);
    int     file_i;
    int     rank_i;
    int     col;
    int     row;
    logic   shade;
    piece_t p;
    file_i = x / TILE_SIZE;
    col    = x % TILE_SIZE;
    rank_i = y / TILE_SIZE;
    row    = y % TILE_SIZE;
    shade  = ((file_i + rank_i) % 2) == 1;
    p      = board_model[rank_i][file_i];
    if (col == 0 || col == 7 || row == 0 || row == 7 || p == 0) return shade;
    return p >= FIRST_WHITE;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_pixel(input pixel_t p);
    logic in_range;
    in_range = (p.x < BOARD_PIX) && (p.y < BOARD_PIX);
    assert (in_range) else begin
      $display("Pixel sent outside the board at x=%0d y=%0d", p.x, p.y);
      errors++;
    end
    if (in_range) begin
      assert (!seen[p.x][p.y]) else begin
        $display("Pixel at x=%0d y=%0d was sent twice", p.x, p.y);
        errors++;
      end
      assert (p.colour === expected_colour(p.x, p.y)) else begin
        $display("[ERROR] pix.colour at x=%h y=%h: got %h, expected %h",
                 p.x, p.y, p.colour, expected_colour(p.x, p.y));
        errors++;
      end
      seen[p.x][p.y] = 1'b1;
      pix_count++;
    end
  endtask

  // Frame buffer model, holds credits back for starve_cycles quiet cycles
  task automatic run_frame_buffer(input int delay_bits, input int starve_cycles);
    int outstanding;
    int sent;
    int quiet;
    int now;
    int due_q [$];
    bit done_seen;
    bit starving;
    bit give;
    outstanding = 0;
    sent        = 0;
    quiet       = 0;
    now         = 0;
    done_seen   = 1'b0;
    starving    = (starve_cycles > 0);
    while (!done_seen || outstanding > 0) begin
      @(negedge clk);
      now++;
      if (pix_valid) begin
        assert (outstanding < PIXEL_CREDITS) else begin
          $display("Pixel sent while all %0d credits were in use", outstanding);
          errors++;
        end
        check_pixel(pix);
        sent++;
        outstanding++;
        due_q.push_back(now + 1 + lfsr_bits(delay_bits));
      end
      give = !starving && due_q.size() > 0 && due_q[0] <= now;
      if (give) begin
        void'(due_q.pop_front());
        outstanding--;
      end
      pix_credit = give;
      if (starving && sent >= PIXEL_CREDITS && !pix_valid) quiet++;
      if (starving && quiet == starve_cycles) begin
        check_value("pixels sent without credit return", sent, PIXEL_CREDITS);
        starving = 1'b0;
      end
      if (render_done) begin
        done_seen = 1'b1;
        check_value("pixel count", pix_count, BOARD_PIX * BOARD_PIX);
      end
    end
    @(negedge clk);
    pix_credit = 1'b0;
  endtask

  task automatic render_and_check(input int delay_bits, input int starve_cycles);
    foreach (seen[x, y]) seen[x][y] = 1'b0;
    pix_count = 0;
    @(negedge clk);
    render_start = 1'b1;
    @(negedge clk);
    render_start = 1'b0;
    run_frame_buffer(delay_bits, starve_cycles);
  endtask

  task automatic run_cmd(input cmd_op_t op, input square_t origin, input square_t dest,
                         input logic exp_err);
    @(negedge clk);
    while (!cmd_ready) @(negedge clk);
    cmd       = '{op: op, origin: origin, dest: dest};
    cmd_valid = 1'b1;
    @(negedge clk);
    cmd_valid = 1'b0;
    while (!cmd_done) begin
      assert (!cmd_ready) else begin
        $display("cmd_ready rose before the command finished");
        errors++;
      end
      @(negedge clk);
    end
    check_value("cmd_err", cmd_err, exp_err);
    if (op == CMD_INIT) begin
      foreach (board_model[r, f]) board_model[r][f] = start_piece_of(f, r);
    end else if (op == CMD_MOVE && !exp_err) begin
      board_model[dest.rank][dest.file]     = board_model[origin.rank][origin.file];
      board_model[origin.rank][origin.file] = '0;
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: %0d errors", tests_run, name, errors - err_before);
    end
  endtask

  task automatic test_reset();
    int err_before;
    err_before = errors;
    check_value("cmd_ready", cmd_ready, 1);
    check_value("cmd_done", cmd_done, 0);
    check_value("render_done", render_done, 0);
    check_value("pix_valid", pix_valid, 0);
    render_and_check(1, 50);  // Empty board shows only square shades
    finish_test("reset and credit stall", err_before);
  endtask

  task automatic test_init_render();
    int err_before;
    err_before = errors;
    run_cmd(CMD_INIT, sq_at(0, 0), sq_at(0, 0), 1'b0);
    render_and_check(1, 0);
    finish_test("init and render", err_before);
  endtask

  task automatic test_move_capture();
    int err_before;
    err_before = errors;
    run_cmd(CMD_MOVE, sq_at(4, 0), sq_at(4, 3), 1'b0);  // e1 to e4
    run_cmd(CMD_MOVE, sq_at(4, 3), sq_at(4, 6), 1'b0);  // Takes the e7 pawn
    render_and_check(1, 0);
    finish_test("move and capture", err_before);
  endtask

  task automatic test_refused();
    int err_before;
    err_before = errors;
    run_cmd(CMD_MOVE, sq_at(3, 3), sq_at(3, 4), 1'b1);  // d4 is empty
    run_cmd(CMD_MOVE, sq_at(0, 0), sq_at(0, 0), 1'b1);
    render_and_check(1, 0);
    finish_test("refused moves", err_before);
  endtask

  task automatic test_back_pressure();
    int err_before;
    err_before = errors;
    render_and_check(3, 0);  // Return delays up to 7 cycles
    finish_test("back-pressure", err_before);
  endtask

  task automatic test_overlap();
    int err_before;
    err_before = errors;
    fork
      render_and_check(1, 0);
      begin
        // Ranks 4 and 6 are rendered long after the move ends
        repeat (30) @(negedge clk);
        run_cmd(CMD_MOVE, sq_at(3, 6), sq_at(3, 4), 1'b0);
      end
    join
    render_and_check(1, 0);
    finish_test("move during render", err_before);
  endtask

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Run stopped after %0d cycles without finishing the tests", cycles);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin : main
    cmd          = '0;
    cmd_valid    = 1'b0;
    render_start = 1'b0;
    pix_credit   = 1'b0;
    lfsr_state   = 32'd72976;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    pix_count    = 0;
    foreach (board_model[r, f]) board_model[r][f] = '0;  // Ranks reset to empty
    wait (arst_n === 1'b1);
    @(negedge clk);
    test_reset();
    test_init_render();
    test_move_capture();
    test_refused();
    test_back_pressure();
    test_overlap();
    $display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- flist.f
design/chess_pkg.sv
design/video_pkg.sv
design/board_ctrl.sv
design/board_port_arbiter.sv
design/board_rank.sv
design/rank_read_merge.sv
design/board_render.sv
design/chess_top.sv
test/tb_clock_gen.sv
test/tb_chess_top.sv
